// File: arg_subparser.f
source/arg_parser_pkg.sv
source/char_fifo.sv
source/char_decoder.sv
source/arg_number_executor.sv
source/arg_result_stage.sv
source/arg_subparser.sv
tests/arg_subparser_checker.sv
tests/arg_subparser_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module arg_subparser_tb \
	-f arg_subparser.f -o arg_subparser_sim || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/arg_subparser_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST PASS" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: source/arg_number_executor.sv
`timescale 1ns/1ns

module arg_number_executor import arg_parser_pkg::*; #(
	parameter int NUM_BITS = 16
) (
	input  logic                 sub_intf,
	input  logic                 rst,
	input  logic                 trigger,
	input  logic [BYTE_BITS-1:0] arg_title,
	input  decoded_char_t        slot,
	input  logic                 slot_valid,
	input  logic                 fifo_empty,
	output logic                 slot_take,
	output logic                 active,
	output arg_result_t          result,
	output logic                 result_valid
);

	localparam int ACC_BITS = NUM_BITS + 4;
	localparam logic [NUM_BITS-1:0] MAG_LIMIT = NUM_BITS'(1) << (NUM_BITS - 1);

	typedef enum logic [2:0] {
		st_idle,
		st_lead, // leading spaces, then the title.
		st_gap, // spaces after the title, then sign or digit.
		st_sign,
		st_int,
		st_frac,
		st_discard
	} state_t;

	state_t state;
	state_t state_next;
	logic negative;
	logic too_big;
	logic [NUM_BITS-1:0] int_acc;
	logic [ACC_BITS-1:0] int_next;
	logic [6:0] frac;
	logic [1:0] frac_cnt;
	logic is_digit;
	logic is_term;
	logic title_match;
	logic fail;
	logic finish;
	logic end_ok;

	assign active = (state != st_idle);
	assign slot_take = active && slot_valid; // every active state eats one char.
	assign is_digit = (slot.cls == cls_digit);
	assign is_term = (slot.cls == cls_space) || (slot.cls == cls_newline);
	assign title_match = (slot.cls == cls_letter) && (slot.code == to_upper(arg_title));
	assign int_next = ACC_BITS'(int_acc) * ACC_BITS'(10) + ACC_BITS'(slot.value);

	always_comb begin
		state_next = state;
		fail = 1'b0;
		finish = 1'b0;
		if (state == st_idle) begin
			if (trigger) begin
				state_next = st_lead;
			end
		end else if (!slot_valid) begin
			finish = fifo_empty; // an empty buffer ends the token like a space.
		end else begin
			case (state)
				st_lead: begin
					if (title_match) begin
						state_next = st_gap;
					end else if (slot.cls != cls_space) begin
						fail = 1'b1;
					end
				end
				st_gap: begin
					if (slot.cls == cls_minus) begin
						state_next = st_sign;
					end else if (is_digit) begin
						state_next = st_int;
					end else if (slot.cls != cls_space) begin
						fail = 1'b1;
					end
				end
				st_sign: begin
					if (is_digit) begin
						state_next = st_int;
					end else begin
						fail = 1'b1;
					end
				end
				st_int: begin
					if (slot.cls == cls_point) begin
						state_next = st_frac;
					end else if (is_term) begin
						finish = 1'b1;
					end else if (!is_digit) begin
						fail = 1'b1;
					end
				end
				st_frac: begin
					if (is_term) begin
						finish = 1'b1;
					end else if (!is_digit) begin
						fail = 1'b1;
					end
				end
				default: begin
					finish = is_term; // discard up to the next separator.
				end
			endcase
			if (fail) begin
				finish = is_term;
				state_next = st_discard;
			end
		end
		if (finish) begin
			state_next = st_idle;
		end
	end

	assign end_ok = !fail && ((state == st_int) || (state == st_frac));
	assign result_valid = finish;
	assign result = '{
		negative: negative,
		int_mag: int_acc,
		frac_hundredths: frac,
		ok: end_ok,
		too_big: too_big,
		newline: slot_valid && (slot.cls == cls_newline)
	};

	always_ff @(posedge sub_intf) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge sub_intf) begin
		if (state == st_idle) begin
			if (trigger) begin
				negative <= 1'b0;
				too_big <= 1'b0;
				int_acc <= '0;
				frac <= '0;
				frac_cnt <= '0;
			end
		end else if (slot_take) begin
			if (state == st_gap && slot.cls == cls_minus) begin
				negative <= 1'b1;
			end
			if (is_digit && (state == st_gap || state == st_sign || state == st_int)) begin
				if (int_next >= ACC_BITS'(MAG_LIMIT)) begin
					too_big <= 1'b1;
					int_acc <= MAG_LIMIT; // saturate.
				end else begin
					int_acc <= int_next[NUM_BITS-1:0];
				end
			end
			if (is_digit && state == st_frac) begin
				if (frac_cnt == 2'd0) begin
					frac <= 7'(slot.value) * 7'd10;
				end else if (frac_cnt == 2'd1) begin
					frac <= frac + 7'(slot.value);
				end
				if (frac_cnt != 2'd2) begin
					frac_cnt <= frac_cnt + 1'b1; // later digits are truncated.
				end
			end
		end
	end

endmodule

// File: source/arg_parser_pkg.sv
package arg_parser_pkg;

	localparam int BYTE_BITS = 8;
	localparam int ARG_NUM_BITS = 16; // must match the top level NUM_BITS.

	localparam logic [BYTE_BITS-1:0] CHAR_NEWLINE = 8'h0A;
	localparam logic [BYTE_BITS-1:0] CHAR_SPACE = 8'h20;
	localparam logic [BYTE_BITS-1:0] CHAR_MINUS = 8'h2D;
	localparam logic [BYTE_BITS-1:0] CHAR_POINT = 8'h2E;
	localparam logic [BYTE_BITS-1:0] CHAR_0 = 8'h30;
	localparam logic [BYTE_BITS-1:0] CHAR_9 = 8'h39;
	localparam logic [BYTE_BITS-1:0] CHAR_A = 8'h41;
	localparam logic [BYTE_BITS-1:0] CHAR_Z = 8'h5A;
	localparam logic [BYTE_BITS-1:0] CHAR_LOWER_A = 8'h61;
	localparam logic [BYTE_BITS-1:0] CHAR_LOWER_Z = 8'h7A;
	localparam logic [BYTE_BITS-1:0] CASE_OFFSET = 8'h20; // distance between the two letter ranges.

	typedef enum logic [2:0] {
		cls_digit,
		cls_minus,
		cls_point,
		cls_letter,
		cls_space,
		cls_newline,
		cls_other
	} char_class_t;

	typedef struct packed {
		char_class_t cls;
		logic [3:0] value; // digit value, zero for anything else.
		logic [BYTE_BITS-1:0] code; // upper case byte.
	} decoded_char_t;

	typedef struct packed {
		logic negative;
		logic [ARG_NUM_BITS-1:0] int_mag;
		logic [6:0] frac_hundredths;
		logic ok;
		logic too_big;
		logic newline;
	} arg_result_t;

	function automatic logic [BYTE_BITS-1:0] to_upper(input logic [BYTE_BITS-1:0] c);
		logic [BYTE_BITS-1:0] u;
		u = c;
		if (c >= CHAR_LOWER_A && c <= CHAR_LOWER_Z) begin
			u = c - CASE_OFFSET;
		end
		return u;
	endfunction

endpackage

// File: source/arg_result_stage.sv
`timescale 1ns/1ns

module arg_result_stage import arg_parser_pkg::*; #(
	parameter int NUM_BITS = 16,
	parameter int PRECISE_NUM_BITS = 24
) (
	input  logic                               sub_intf,
	input  logic                               rst,
	input  arg_result_t                        result,
	input  logic                               result_valid,
	output logic                               done,
	output logic                               success,
	output logic                               arg_too_big,
	output logic                               is_newline,
	output logic signed [NUM_BITS-1:0]         num,
	output logic signed [PRECISE_NUM_BITS-1:0] precise_num
);

	localparam logic [PRECISE_NUM_BITS-1:0] HUNDRED = PRECISE_NUM_BITS'(100);

	logic keep;
	logic [NUM_BITS-1:0] int_mag;
	logic [6:0] frac_mag;
	logic [PRECISE_NUM_BITS-1:0] hund_mag;
	logic signed [NUM_BITS-1:0] num_val;
	logic signed [PRECISE_NUM_BITS-1:0] precise_val;

	assign keep = result.ok && !result.too_big;

	// failed or oversized arguments report zero.
	assign int_mag = keep ? NUM_BITS'(result.int_mag) : '0;
	assign frac_mag = keep ? result.frac_hundredths : '0;

	assign hund_mag = PRECISE_NUM_BITS'(int_mag) * HUNDRED + PRECISE_NUM_BITS'(frac_mag);

	always_comb begin
		if (result.negative) begin
			num_val = -$signed(int_mag);
			precise_val = -$signed(hund_mag);
		end else begin
			num_val = $signed(int_mag);
			precise_val = $signed(hund_mag);
		end
	end

	always_ff @(posedge sub_intf) begin
		if (rst) begin
			done <= 1'b0;
			success <= 1'b0;
			arg_too_big <= 1'b0;
			is_newline <= 1'b0;
			num <= '0;
			precise_num <= '0;
		end else begin
			done <= result_valid; // one cycle after the executor ends.
			if (result_valid) begin
				success <= keep;
				arg_too_big <= result.too_big;
				is_newline <= result.newline;
				num <= num_val;
				precise_num <= precise_val;
			end
		end
	end

endmodule

// File: source/arg_subparser.sv
`timescale 1ns/1ns

module arg_subparser import arg_parser_pkg::*; #(
	parameter int NUM_BITS = 16,
	parameter int PRECISE_NUM_BITS = 24,
	parameter int FIFO_DEPTH = 64
) (
	input  logic                               sub_intf,
	input  logic                               rst,
	input  logic [BYTE_BITS-1:0]               char_in,
	input  logic                               char_valid,
	input  logic                               trigger,
	input  logic [BYTE_BITS-1:0]               arg_title,
	output logic                               full,
	output logic                               empty,
	output logic                               done,
	output logic                               success,
	output logic                               arg_too_big,
	output logic                               is_newline,
	output logic signed [NUM_BITS-1:0]         num,
	output logic signed [PRECISE_NUM_BITS-1:0] precise_num
);

	logic [BYTE_BITS-1:0] head;
	logic fifo_pop;
	decoded_char_t slot;
	logic slot_valid;
	logic slot_take;
	logic active;
	arg_result_t result;
	logic result_valid;

	char_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) char_fifo_i (
		.sub_intf(sub_intf),
		.rst(rst),
		.wr_data(char_in),
		.wr_en(char_valid),
		.rd_en(fifo_pop),
		.rd_data(head),
		.empty(empty),
		.full(full)
	);

	char_decoder char_decoder_i (
		.sub_intf(sub_intf),
		.rst(rst),
		.head(head),
		.fifo_empty(empty),
		.active(active),
		.slot_take(slot_take),
		.fifo_pop(fifo_pop),
		.slot(slot),
		.slot_valid(slot_valid)
	);

	arg_number_executor #(
		.NUM_BITS(NUM_BITS)
	) arg_number_executor_i (
		.sub_intf(sub_intf),
		.rst(rst),
		.trigger(trigger),
		.arg_title(arg_title),
		.slot(slot),
		.slot_valid(slot_valid),
		.fifo_empty(empty),
		.slot_take(slot_take),
		.active(active),
		.result(result),
		.result_valid(result_valid)
	);

	arg_result_stage #(
		.NUM_BITS(NUM_BITS),
		.PRECISE_NUM_BITS(PRECISE_NUM_BITS)
	) arg_result_stage_i (
		.sub_intf(sub_intf),
		.rst(rst),
		.result(result),
		.result_valid(result_valid),
		.done(done),
		.success(success),
		.arg_too_big(arg_too_big),
		.is_newline(is_newline),
		.num(num),
		.precise_num(precise_num)
	);

endmodule

// File: source/char_decoder.sv
`timescale 1ns/1ns

module char_decoder import arg_parser_pkg::*; (
	input  logic                 sub_intf,
	input  logic                 rst,
	input  logic [BYTE_BITS-1:0] head,
	input  logic                 fifo_empty,
	input  logic                 active,
	input  logic                 slot_take,
	output logic                 fifo_pop,
	output decoded_char_t        slot,
	output logic                 slot_valid
);

	decoded_char_t head_dec;
	logic [BYTE_BITS-1:0] head_upper;

	assign head_upper = to_upper(head);

	always_comb begin
		head_dec.code = head_upper;
		head_dec.value = 4'd0;
		if (head >= CHAR_0 && head <= CHAR_9) begin
			head_dec.cls = cls_digit;
			head_dec.value = head[3:0]; // low nibble of an ascii digit.
		end else if (head == CHAR_MINUS) begin
			head_dec.cls = cls_minus;
		end else if (head == CHAR_POINT) begin
			head_dec.cls = cls_point;
		end else if (head_upper >= CHAR_A && head_upper <= CHAR_Z) begin
			head_dec.cls = cls_letter;
		end else if (head == CHAR_SPACE) begin
			head_dec.cls = cls_space;
		end else if (head == CHAR_NEWLINE) begin
			head_dec.cls = cls_newline;
		end else begin
			head_dec.cls = cls_other;
		end
	end

	// refill when the slot is free or emptied this cycle.
	assign fifo_pop = active && !fifo_empty && (!slot_valid || slot_take);

	always_ff @(posedge sub_intf) begin
		if (rst) begin
			slot_valid <= 1'b0;
		end else if (fifo_pop) begin
			slot_valid <= 1'b1;
		end else if (slot_take) begin
			slot_valid <= 1'b0;
		end
	end

	always_ff @(posedge sub_intf) begin
		if (fifo_pop) begin
			slot <= head_dec;
		end
	end

endmodule

// File: source/char_fifo.sv
`timescale 1ns/1ns

module char_fifo import arg_parser_pkg::*; #(
	parameter int FIFO_DEPTH = 64
) (
	input  logic                 sub_intf,
	input  logic                 rst,
	input  logic [BYTE_BITS-1:0] wr_data,
	input  logic                 wr_en,
	input  logic                 rd_en,
	output logic [BYTE_BITS-1:0] rd_data,
	output logic                 empty,
	output logic                 full
);

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);

	logic [BYTE_BITS-1:0] mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0] count;
	logic do_wr;
	logic do_rd;

	assign empty = (count == '0);
	assign full = (count == (PTR_BITS+1)'(FIFO_DEPTH));
	assign do_wr = wr_en && !full; // writes into a full buffer are lost.
	assign do_rd = rd_en && !empty;
	assign rd_data = mem[rd_ptr]; // head is always on the output.

	always_ff @(posedge sub_intf) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge sub_intf) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps since the depth is a power of two.
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

endmodule

// File: tests/arg_subparser_checker.sv
`timescale 1ns/1ns

module arg_subparser_checker import arg_parser_pkg::*; #(
	parameter int NUM_BITS = 16,
	parameter int PRECISE_NUM_BITS = 24
) (
	input logic                               sub_intf,
	input logic                               rst,
	input logic                               full,
	input logic                               empty,
	input logic                               done,
	input logic                               success,
	input logic signed [NUM_BITS-1:0]         num,
	input logic signed [PRECISE_NUM_BITS-1:0] precise_num,
	input logic                               active,
	input logic                               slot_valid
);

	// the result struct is declared at the package width.
	a_num_width: assert property (@(posedge sub_intf) NUM_BITS == ARG_NUM_BITS)
		else $error("top level NUM_BITS differs from ARG_NUM_BITS");

	a_done_pulse: assert property (@(posedge sub_intf) disable iff (rst) done |=> !done)
		else $error("done is high for more than one cycle");

	a_fail_zero: assert property (@(posedge sub_intf) disable iff (rst)
		(done && !success) |-> (num == '0 && precise_num == '0))
		else $error("failed argument reports a nonzero value");

	// integer part and hundredths describe the same value.
	a_num_precise: assert property (@(posedge sub_intf) disable iff (rst)
		(done && success) |-> (num == precise_num / 100))
		else $error("num does not match the integer part of precise_num");

	// a leftover character waits in the slot for the next trigger.
	a_slot_kept: assert property (@(posedge sub_intf) disable iff (rst)
		(!active && slot_valid) |=> slot_valid)
		else $error("decoder slot lost its character while no parse runs");

	a_reset_state: assert property (@(posedge sub_intf)
		rst |=> (!done && empty && !full && !active && !slot_valid && num == '0))
		else $error("state after reset is wrong");

endmodule

bind arg_subparser arg_subparser_checker #(
	.NUM_BITS(NUM_BITS),
	.PRECISE_NUM_BITS(PRECISE_NUM_BITS)
) arg_subparser_checker_i (
	.sub_intf(sub_intf),
	.rst(rst),
	.full(full),
	.empty(empty),
	.done(done),
	.success(success),
	.num(num),
	.precise_num(precise_num),
	.active(active),
	.slot_valid(slot_valid)
);

// File: tests/arg_subparser_tb.sv
`timescale 1ns/1ns

module arg_subparser_tb import arg_parser_pkg::*; ();

	localparam int NUM_BITS = ARG_NUM_BITS;
	localparam int PRECISE_NUM_BITS = 24;
	localparam int FIFO_DEPTH = 64;
	localparam int CLK_PERIOD = 40;
	localparam int SEED = 66;
	localparam int NUM_RANDOM = 40;
	localparam int NUM_FIXED = 22;
	localparam int NUM_TESTS = NUM_RANDOM + NUM_FIXED;
	localparam int DONE_LIMIT = 100; // cycles allowed from trigger to done.
	localparam longint MAG_LIMIT = longint'(1) << (NUM_BITS - 1);
	localparam byte NEWLINE = 8'h0A;

	logic sub_intf = 1'b0;
	logic rst;
	logic [BYTE_BITS-1:0] char_in;
	logic char_valid;
	logic trigger;
	logic [BYTE_BITS-1:0] arg_title;
	logic full;
	logic empty;
	logic done;
	logic success;
	logic arg_too_big;
	logic is_newline;
	logic signed [NUM_BITS-1:0] num;
	logic signed [PRECISE_NUM_BITS-1:0] precise_num;

	byte stream_q[$]; // characters written and not yet parsed.
	int test_count = 0;
	int pass_count = 0;
	int fail_count = 0;

	always #(CLK_PERIOD / 2) sub_intf = ~sub_intf;

	arg_subparser #(
		.NUM_BITS(NUM_BITS),
		.PRECISE_NUM_BITS(PRECISE_NUM_BITS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) arg_subparser_i (
		.sub_intf(sub_intf),
		.rst(rst),
		.char_in(char_in),
		.char_valid(char_valid),
		.trigger(trigger),
		.arg_title(arg_title),
		.full(full),
		.empty(empty),
		.done(done),
		.success(success),
		.arg_too_big(arg_too_big),
		.is_newline(is_newline),
		.num(num),
		.precise_num(precise_num)
	);

	function automatic byte upcase(input byte c);
		byte u;
		u = c;
		if (c >= "a" && c <= "z") begin
			u = c - 8'h20;
		end
		return u;
	endfunction

	function automatic bit is_digit(input byte c);
		return c >= "0" && c <= "9";
	endfunction

	function automatic bit is_sep(input byte c);
		return c == " " || c == NEWLINE;
	endfunction

	function automatic string random_token(input byte title);
		string s;
		int n_int;
		int n_frac;
		s = "";
		repeat ($urandom_range(2)) begin
			s = $sformatf("%s ", s);
		end
		s = $sformatf("%s%c", s, ($urandom_range(1) == 1) ? title + 8'h20 : title);
		repeat ($urandom_range(1)) begin
			s = $sformatf("%s ", s);
		end
		if ($urandom_range(1) == 1) begin
			s = $sformatf("%s-", s);
		end
		n_int = $urandom_range(5, 1);
		for (int i = 0; i < n_int; i++) begin
			// five digit values stay below 30000.
			s = $sformatf("%s%0d", s, (i == 0 && n_int == 5) ? $urandom_range(2) : $urandom_range(9));
		end
		n_frac = $urandom_range(4);
		if (n_frac > 0 || $urandom_range(1) == 1) begin
			s = $sformatf("%s.", s);
		end
		for (int i = 0; i < n_frac; i++) begin
			s = $sformatf("%s%0d", s, $urandom_range(9));
		end
		if ($urandom_range(1) == 1) begin
			s = $sformatf("%s\n", s);
		end else begin
			s = $sformatf("%s ", s);
		end
		return s;
	endfunction

	// reference parse that consumes the next argument from stream_q.
	task automatic model_parse(input byte title, output bit succ, output bit big, output bit nl,
			output longint v_num, output longint v_prec);
		byte body[$];
		bit matched;
		bit ok;
		bit neg;
		longint mag;
		int frac;
		int nfrac;
		int i;
		matched = 1'b0;
		ok = 1'b0;
		neg = 1'b0;
		big = 1'b0;
		nl = 1'b0;
		mag = 0;
		frac = 0;
		nfrac = 0;
		i = 0;
		while (stream_q.size() > 0 && stream_q[0] == " ") begin
			void'(stream_q.pop_front());
		end
		if (stream_q.size() > 0 && upcase(stream_q[0]) >= "A" && upcase(stream_q[0]) <= "Z"
				&& upcase(stream_q[0]) == upcase(title)) begin
			matched = 1'b1;
			void'(stream_q.pop_front());
			while (stream_q.size() > 0 && stream_q[0] == " ") begin
				void'(stream_q.pop_front());
			end
		end
		while (stream_q.size() > 0 && !is_sep(stream_q[0])) begin
			body.push_back(stream_q.pop_front());
		end
		if (stream_q.size() > 0) begin
			nl = (stream_q.pop_front() == NEWLINE); // an empty buffer ends like a space.
		end
		if (matched) begin
			if (body.size() > 0 && body[0] == "-") begin
				neg = 1'b1;
				i = 1;
			end
			ok = (i < body.size()) && is_digit(body[i]);
			while (i < body.size() && is_digit(body[i])) begin
				mag = mag * 10 + longint'(body[i] - "0");
				if (mag >= MAG_LIMIT) begin
					big = 1'b1;
					mag = MAG_LIMIT;
				end
				i++;
			end
			if (i < body.size() && body[i] == ".") begin
				i++;
				while (i < body.size() && is_digit(body[i])) begin
					if (nfrac == 0) begin
						frac = int'(body[i] - "0") * 10;
					end else if (nfrac == 1) begin
						frac = frac + int'(body[i] - "0");
					end
					nfrac++;
					i++;
				end
			end
			if (i != body.size()) begin
				ok = 1'b0;
			end
		end
		succ = ok && !big;
		v_num = succ ? (neg ? -mag : mag) : 0;
		v_prec = succ ? (neg ? -(mag * 100 + frac) : mag * 100 + frac) : 0;
	endtask

	task automatic write_chars(input string s);
		for (int i = 0; i < s.len(); i++) begin
			@(posedge sub_intf);
			char_in <= s[i];
			char_valid <= 1'b1;
			stream_q.push_back(s[i]);
		end
		@(posedge sub_intf);
		char_valid <= 1'b0;
	endtask

	task automatic trigger_and_wait(input byte title, output bit got_done);
		int cycles;
		@(posedge sub_intf);
		trigger <= 1'b1;
		arg_title <= title;
		@(posedge sub_intf);
		trigger <= 1'b0;
		got_done = 1'b0;
		cycles = 0;
		while (!got_done && cycles < DONE_LIMIT) begin
			@(negedge sub_intf);
			got_done = done;
			cycles++;
		end
	endtask

	task automatic report_value(input string label, input string field, input longint exp_v,
			input longint got_v);
		$display("ERROR at %0t ns: %s, %s expected %0d, got %0d", $time, label, field, exp_v,
			got_v);
	endtask

	task automatic check_token(input byte title, input string label);
		bit got_done;
		bit exp_succ;
		bit exp_big;
		bit exp_nl;
		longint exp_num;
		longint exp_prec;
		int exp_count;
		bit pass;
		model_parse(title, exp_succ, exp_big, exp_nl, exp_num, exp_prec);
		// the decoder slot holds the first character left over.
		exp_count = (stream_q.size() > 0) ? stream_q.size() - 1 : 0;
		trigger_and_wait(title, got_done);
		pass = 1'b1;
		if (!got_done) begin
			$display("no done pulse within %0d cycles of trigger for %s", DONE_LIMIT, label);
			pass = 1'b0;
		end else begin
			if (success !== exp_succ) begin
				report_value(label, "success", exp_succ, success);
				pass = 1'b0;
			end
			if (arg_too_big !== exp_big) begin
				report_value(label, "arg_too_big", exp_big, arg_too_big);
				pass = 1'b0;
			end
			if (is_newline !== exp_nl) begin
				report_value(label, "is_newline", exp_nl, is_newline);
				pass = 1'b0;
			end
			if (longint'(num) != exp_num) begin
				report_value(label, "num", exp_num, num);
				pass = 1'b0;
			end
			if (longint'(precise_num) != exp_prec) begin
				report_value(label, "precise_num", exp_prec, precise_num);
				pass = 1'b0;
			end
			if (empty !== (exp_count == 0)) begin
				report_value(label, "empty", exp_count == 0, empty);
				pass = 1'b0;
			end
			if (full !== (exp_count >= FIFO_DEPTH)) begin
				report_value(label, "full", exp_count >= FIFO_DEPTH, full);
				pass = 1'b0;
			end
		end
		test_count++;
		if (pass) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		$display("test %0d %s (%c): %s", test_count, label, title, pass ? "passed" : "failed");
	endtask

	task automatic run_line(input string s, input string titles, input string label);
		write_chars(s);
		for (int i = 0; i < titles.len(); i++) begin
			check_token(titles[i], label);
		end
	endtask

	initial begin
		byte title;
		void'($urandom(SEED));
		rst = 1'b1;
		char_in = '0;
		char_valid = 1'b0;
		trigger = 1'b0;
		arg_title = "X";
		repeat (10) begin
			@(posedge sub_intf);
		end
		rst <= 1'b0;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			title = "A" + 8'($urandom_range(25));
			write_chars(random_token(title));
			check_token(title, "random token");
		end
		run_line("Y5 ", "X", "wrong title letter");
		run_line("x-3.25 ", "X", "lower case title");
		run_line("Z7.5\n", "z", "lower case arg_title");
		run_line("X--12 X7 ", "XX", "double minus");
		run_line("X12.a3 X8 ", "XX", "letter in fraction");
		run_line("X- X9 ", "XX", "lone minus");
		run_line("X. X10 ", "XX", "lone point");
		run_line("X1#2 X11\n", "XX", "stray symbol");
		run_line("X32768 ", "X", "integer at limit");
		run_line("X-99999 ", "X", "large negative");
		run_line("X123456.7\n", "X", "six digit integer");
		run_line("X1.5 Y-2 Z30\n", "XYZ", "line of tokens");
		run_line("X12 Y-0.07 Z4", "XYZ", "line cut off");
		$display("tests run %0d, passed %0d, failed %0d", test_count, pass_count, fail_count);
		if (fail_count == 0 && test_count == NUM_TESTS) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		#(NUM_TESTS * 200 * CLK_PERIOD);
		$display("run timed out after %0d cycles with tests unfinished", NUM_TESTS * 200);
		$display("TEST FAIL");
		$finish;
	end

endmodule
